// File: design/ratio_cfg.svh
`ifndef RATIO_CFG_SVH
`define RATIO_CFG_SVH

// ======================================================================
// Ratio unit widths
// ======================================================================

// Signed operand width at the unit boundary
`define RATIO_OPND_W 49

// Unsigned magnitude, wide enough for the most negative operand
`define RATIO_MAG_W 49

// Signed result, one bit wider so min / -1 still fits
`define RATIO_RES_W 50

// Divider step counter
`define RATIO_CNT_W 6

// Accepted start to result_valid, in clocks
`define RATIO_LATENCY (`RATIO_MAG_W + 4)

`endif

// File: design/ratio_pkg.sv
`include "ratio_cfg.svh"

package ratio_pkg;

    // ==================================================================
    // Datapath word types
    // ==================================================================

    // Signed dividend or divisor as presented at the top
    typedef logic signed [`RATIO_OPND_W-1:0] opnd_t;

    // Unsigned magnitude fed through the divider
    typedef logic [`RATIO_MAG_W-1:0] mag_t;

    // Signed quotient or remainder after fix-up
    typedef logic signed [`RATIO_RES_W-1:0] res_t;

endpackage

// File: design/ratio_operand_capture.sv
`timescale 1ns/100ps
`include "ratio_cfg.svh"

module ratio_operand_capture (
    input  logic             clk_sys,
    input  logic             rst_sys_n,
    input  logic             start,
    input  ratio_pkg::opnd_t dividend,
    input  ratio_pkg::opnd_t divisor,
    input  logic             result_valid,
    output logic             busy,
    output logic             div_start,
    output logic             zero_div,
    output ratio_pkg::mag_t  mag_a,
    output ratio_pkg::mag_t  mag_b,
    output logic             neg_quot,
    output logic             neg_rmn
);
    import ratio_pkg::*;

    logic sign_a;
    logic sign_b;
    logic accept;
    mag_t abs_a;
    mag_t abs_b;

    // Operand signs
    assign sign_a = dividend[`RATIO_OPND_W-1];
    assign sign_b = divisor[`RATIO_OPND_W-1];

    // Two's-complement magnitudes
    // -2^48 maps to 2^48, still fits unsigned
    assign abs_a = sign_a ? mag_t'(-dividend) : mag_t'(dividend);
    assign abs_b = sign_b ? mag_t'(-divisor) : mag_t'(divisor);

    // Start only counts while idle
    assign accept = start && !busy;

    // ==================================================================
    // Control
    // ==================================================================

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            busy      <= 1'b0;
            div_start <= 1'b0;
            zero_div  <= 1'b0;
        end else begin
            // One of the two strobes per accepted start
            div_start <= accept && (divisor != '0);
            zero_div  <= accept && (divisor == '0);
            if (accept) begin
                busy <= 1'b1;
            end else if (result_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Operand registers, held until the next capture
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            mag_a    <= abs_a;
            mag_b    <= abs_b;
            // Truncating division sign rules
            neg_quot <= sign_a ^ sign_b;
            neg_rmn  <= sign_a;
        end
    end

    // Divide and zero-divisor paths are exclusive
    a_start_excl: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        !(div_start && zero_div));

endmodule

// File: design/serial_divider.sv
`timescale 1ns/100ps
`include "ratio_cfg.svh"

module serial_divider (
    input  logic            clk_sys,
    input  logic            rst_sys_n,
    input  logic            div_start,
    input  ratio_pkg::mag_t mag_a,
    input  ratio_pkg::mag_t mag_b,
    output logic            div_done,
    output ratio_pkg::mag_t quot_mag,
    output ratio_pkg::mag_t rmn_mag
);
    import ratio_pkg::*;

    localparam int W = `RATIO_MAG_W;
    localparam int unsigned LAST_STEP = `RATIO_MAG_W - 1;

    // One-hot states
    localparam logic [3:0] ST_IDLE   = 4'b0001;
    localparam logic [3:0] ST_LOAD   = 4'b0010;
    localparam logic [3:0] ST_ITER   = 4'b0100;
    localparam logic [3:0] ST_FINISH = 4'b1000;

    logic [3:0]              state;
    logic [3:0]              state_nxt;
    logic [`RATIO_CNT_W-1:0] step_cnt;
    logic                    last_step;
    // Remainder in upper half, dividend then quotient bits in lower
    logic [2*W-1:0]          work;
    mag_t                    dvsr;
    // Shifted partial remainder and trial difference
    logic [W:0]              partial;
    logic [W+1:0]            diff;

    assign last_step = (step_cnt == LAST_STEP[`RATIO_CNT_W-1:0]);

    // ==================================================================
    // FSM
    // ==================================================================

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            ST_IDLE:   state_nxt = div_start ? ST_LOAD : ST_IDLE;
            ST_LOAD:   state_nxt = ST_ITER;
            ST_ITER:   state_nxt = last_step ? ST_FINISH : ST_ITER;
            ST_FINISH: state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    // Counter rearmed in load, runs W steps
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            step_cnt <= '0;
        end else if (state == ST_LOAD) begin
            step_cnt <= '0;
        end else if (state == ST_ITER) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // ==================================================================
    // Shift-subtract datapath
    // ==================================================================

    // Remainder shifted left with next dividend bit
    assign partial = work[2*W-1:W-1];
    assign diff    = {1'b0, partial} - {2'b00, dvsr};

    always_ff @(posedge clk_sys) begin
        if ((state == ST_IDLE) && div_start) begin
            work <= {{W{1'b0}}, mag_a};
            dvsr <= mag_b;
        end else if (state == ST_ITER) begin
            if (diff[W+1]) begin
                // Trial negative, restore and shift in 0
                work <= {work[2*W-2:0], 1'b0};
            end else begin
                work <= {diff[W-1:0], work[W-2:0], 1'b1};
            end
        end
    end

    // Finish state bit is the done pulse
    assign div_done = state[3];
    assign quot_mag = work[W-1:0];
    assign rmn_mag  = work[2*W-1:W];

    a_start_idle: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        div_start |-> (state == ST_IDLE));

    a_done_pulse: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        div_done |=> !div_done);

    // Fixed turnaround from start pulse to done
    a_done_time: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        div_start |-> ##(`RATIO_LATENCY - 2) div_done);

endmodule

// File: design/ratio_sign_fixup.sv
`timescale 1ns/100ps

module ratio_sign_fixup (
    input  logic            clk_sys,
    input  logic            rst_sys_n,
    input  logic            div_done,
    input  logic            zero_div,
    input  ratio_pkg::mag_t quot_mag,
    input  ratio_pkg::mag_t rmn_mag,
    input  logic            neg_quot,
    input  logic            neg_rmn,
    output logic            result_valid,
    output ratio_pkg::res_t quotient,
    output ratio_pkg::res_t remainder,
    output logic            div_zero
);
    import ratio_pkg::*;

    res_t quot_wide;
    res_t rmn_wide;
    res_t quot_sgn;
    res_t rmn_sgn;

    // Zero-extend magnitudes to result width
    assign quot_wide = res_t'({1'b0, quot_mag});
    assign rmn_wide  = res_t'({1'b0, rmn_mag});

    // Negate where the captured sign asks for it
    assign quot_sgn = neg_quot ? -quot_wide : quot_wide;
    assign rmn_sgn  = neg_rmn ? -rmn_wide : rmn_wide;

    // ==================================================================
    // Result registers
    // ==================================================================

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            result_valid <= 1'b0;
            quotient     <= '0;
            remainder    <= '0;
            div_zero     <= 1'b0;
        end else begin
            result_valid <= div_done || zero_div;
            if (div_done) begin
                quotient  <= quot_sgn;
                remainder <= rmn_sgn;
                div_zero  <= 1'b0;
            end else if (zero_div) begin
                // Zero divisor returns zero results and a flag
                quotient  <= '0;
                remainder <= '0;
                div_zero  <= 1'b1;
            end
        end
    end

    // Capture never issues a zero-divide while the divider finishes
    a_src_excl: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        !(div_done && zero_div));

endmodule

// File: design/ratio_unit_top.sv
`timescale 1ns/100ps

module ratio_unit_top (
    input  logic             clk_sys,
    input  logic             rst_sys_n,
    input  logic             start,
    input  ratio_pkg::opnd_t dividend,
    input  ratio_pkg::opnd_t divisor,
    output logic             busy,
    output logic             result_valid,
    output ratio_pkg::res_t  quotient,
    output ratio_pkg::res_t  remainder,
    output logic             div_zero
);
    import ratio_pkg::*;

    // Capture to divider
    logic div_start;
    mag_t mag_a;
    mag_t mag_b;
    // Capture to fix-up
    logic zero_div;
    logic neg_quot;
    logic neg_rmn;
    // Divider to fix-up
    logic div_done;
    mag_t quot_mag;
    mag_t rmn_mag;

    ratio_operand_capture u_capture (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .start        (start),
        .dividend     (dividend),
        .divisor      (divisor),
        .result_valid (result_valid),
        .busy         (busy),
        .div_start    (div_start),
        .zero_div     (zero_div),
        .mag_a        (mag_a),
        .mag_b        (mag_b),
        .neg_quot     (neg_quot),
        .neg_rmn      (neg_rmn)
    );

    serial_divider u_divider (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .div_start (div_start),
        .mag_a     (mag_a),
        .mag_b     (mag_b),
        .div_done  (div_done),
        .quot_mag  (quot_mag),
        .rmn_mag   (rmn_mag)
    );

    ratio_sign_fixup u_fixup (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .div_done     (div_done),
        .zero_div     (zero_div),
        .quot_mag     (quot_mag),
        .rmn_mag      (rmn_mag),
        .neg_quot     (neg_quot),
        .neg_rmn      (neg_rmn),
        .result_valid (result_valid),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_zero     (div_zero)
    );

endmodule

// File: dv/ratio_unit_tb.sv
`timescale 1ns/100ps
`include "ratio_cfg.svh"

module ratio_unit_tb;
    import ratio_pkg::*;

    localparam int MAX_WAIT = 200;
    localparam opnd_t OPND_MIN = {1'b1, {(`RATIO_OPND_W-1){1'b0}}};

    logic  clk_sys;
    logic  rst_sys_n;
    logic  start;
    opnd_t dividend;
    opnd_t divisor;
    logic  busy;
    logic  result_valid;
    res_t  quotient;
    res_t  remainder;
    logic  div_zero;
    int    err_cnt;
    int    test_cnt;
    int    seed;

    ratio_unit_top UUT (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .start        (start),
        .dividend     (dividend),
        .divisor      (divisor),
        .busy         (busy),
        .result_valid (result_valid),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_zero     (div_zero)
    );

    // 40 ns clock
    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // ==================================================================
    // Checking and waiting
    // ==================================================================

    task automatic check_val(input string msg, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    // Edges from the start sampling edge until result_valid is seen
    task automatic wait_result(output int edges);
        int cyc;
        cyc = 0;
        edges = -1;
        while ((edges < 0) && (cyc < MAX_WAIT)) begin
            @(negedge clk_sys);
            if (result_valid) begin
                edges = cyc + 1;
            end else begin
                cyc++;
            end
        end
        if (edges < 0) begin
            err_cnt++;
            $display("timeout at %0t ns: result_valid never went high", $time);
        end
    endtask

    task automatic wait_idle();
        int cyc;
        cyc = 0;
        while (busy && (cyc < MAX_WAIT)) begin
            @(negedge clk_sys);
            cyc++;
        end
        if (busy) begin
            err_cnt++;
            $display("timeout at %0t ns: busy stayed high", $time);
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        test_cnt++;
        if (err_cnt == errs_at_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed, %0d errors", name, err_cnt - errs_at_start);
        end
    endtask

    // Truncating division by sign and magnitude
    // quotient sign is the xor of signs, remainder follows the dividend
    function automatic void model_div(input longint a, input longint b,
                                      output longint q, output longint r);
        longint ma;
        longint mb;
        ma = (a < 0) ? -a : a;
        mb = (b < 0) ? -b : b;
        q = ma / mb;
        r = ma % mb;
        if ((a < 0) != (b < 0)) begin
            q = -q;
        end
        if (a < 0) begin
            r = -r;
        end
    endfunction

    // ==================================================================
    // Stimulus
    // ==================================================================

    // Returns on the edge that samples start
    task automatic issue_start(input longint a, input longint b);
        @(posedge clk_sys);
        start    <= 1'b1;
        dividend <= opnd_t'(a);
        divisor  <= opnd_t'(b);
        @(posedge clk_sys);
        start <= 1'b0;
    endtask

    task automatic run_div(input string tag, input longint a, input longint b);
        longint exp_q;
        longint exp_r;
        int     edges;
        model_div(a, b, exp_q, exp_r);
        issue_start(a, b);
        wait_result(edges);
        check_val({tag, " latency"}, 64'(edges), 64'(`RATIO_LATENCY));
        check_val({tag, " quotient"}, 64'(quotient), exp_q);
        check_val({tag, " remainder"}, 64'(remainder), exp_r);
        check_val({tag, " div_zero"}, 64'(div_zero), 64'sd0);
        wait_idle();
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_cnt;
        @(negedge clk_sys);
        check_val("reset busy", 64'(busy), 64'sd0);
        check_val("reset result_valid", 64'(result_valid), 64'sd0);
        check_val("reset div_zero", 64'(div_zero), 64'sd0);
        check_val("reset quotient", 64'(quotient), 64'sd0);
        check_val("reset remainder", 64'(remainder), 64'sd0);
        end_test("reset state", e0);
    endtask

    task automatic test_positive();
        int e0;
        e0 = err_cnt;
        run_div("pos 100/7", 100, 7);
        run_div("pos small/large", 5, 9);
        run_div("pos equal", 123456789, 123456789);
        run_div("pos div one", longint'(~OPND_MIN), 1);
        run_div("pos large/3", 64'sd200000000000000, 3);
        end_test("positive operands", e0);
    endtask

    task automatic test_signs();
        int e0;
        e0 = err_cnt;
        run_div("sign +/+", 100, 7);
        run_div("sign -/+", -100, 7);
        run_div("sign +/-", 100, -7);
        run_div("sign -/-", -100, -7);
        // Only case whose quotient needs the extra result bit
        run_div("sign min/-1", longint'(OPND_MIN), -1);
        end_test("sign handling", e0);
    endtask

    task automatic test_zero_div();
        int e0;
        int edges;
        e0 = err_cnt;
        // Nonzero quotient and remainder left behind, so the clear shows
        run_div("zero prior", -100, 7);
        issue_start(-98765, 0);
        wait_result(edges);
        check_val("zero latency", 64'(edges), 64'sd2);
        check_val("zero div_zero", 64'(div_zero), 64'sd1);
        check_val("zero quotient", 64'(quotient), 64'sd0);
        check_val("zero remainder", 64'(remainder), 64'sd0);
        wait_idle();
        end_test("zero divisor", e0);
    endtask

    task automatic test_random();
        int     e0;
        longint a;
        longint b;
        int     sh;
        e0 = err_cnt;
        for (int i = 0; i < 20; i++) begin
            a = longint'(opnd_t'({$random(seed), $random(seed)}));
            b = longint'(opnd_t'({$random(seed), $random(seed)}));
            // Shrink divisor by a random amount for varied quotient sizes
            sh = $unsigned($random(seed)) % 48;
            b = b >>> sh;
            if (b == 0) begin
                b = 1;
            end
            run_div($sformatf("random %0d", i), a, b);
        end
        end_test("random operands", e0);
    endtask

    task automatic test_start_busy();
        int     e0;
        int     edges;
        longint exp_q;
        longint exp_r;
        e0 = err_cnt;
        model_div(-77777777, 1234, exp_q, exp_r);
        issue_start(-77777777, 1234);
        repeat (5) @(posedge clk_sys);
        // Second strobe lands mid-division
        start    <= 1'b1;
        dividend <= opnd_t'(999);
        divisor  <= opnd_t'(0);
        @(posedge clk_sys);
        start <= 1'b0;
        wait_result(edges);
        check_val("busy quotient", 64'(quotient), exp_q);
        check_val("busy remainder", 64'(remainder), exp_r);
        check_val("busy div_zero", 64'(div_zero), 64'sd0);
        @(negedge clk_sys);
        check_val("busy after result", 64'(busy), 64'sd0);
        end_test("start while busy", e0);
    endtask

    initial begin
        seed      = 70;
        err_cnt   = 0;
        test_cnt  = 0;
        rst_sys_n = 1'b0;
        start     = 1'b0;
        dividend  = '0;
        divisor   = '0;
        repeat (16) @(posedge clk_sys);
        rst_sys_n <= 1'b1;
        test_reset();
        test_positive();
        test_signs();
        test_zero_div();
        test_random();
        test_start_busy();
        $display("tests %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/ratio_pkg.sv
design/ratio_operand_capture.sv
design/serial_divider.sv
design/ratio_sign_fixup.sv
design/ratio_unit_top.sv
dv/ratio_unit_tb.sv

// File: Makefile
SIM  := obj_dir/Vratio_unit_tb
SRCS := src.f design/ratio_cfg.svh $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module ratio_unit_tb

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation reported failures"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
